/* filelist.f */
+incdir+.
img_mem_pkg.sv
img_pix_pkg.sv
img_fetch_regs.sv
img_word_fifo.sv
img_burst_reader.sv
img_pixel_unpack.sv
img_border_pad.sv
img_fetch_top.sv
tb_burst_mem.sv
tb_img_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f filelist.f \
    --top-module tb_img_fetch -o tb_img_fetch > build.log 2>&1 \
    && ./obj_dir/tb_img_fetch > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

/* tb_img_fetch.sv */
// Testbench for the image fetch subsystem. Sets up frames over AXI4-Lite,
// serves bursts from a random memory image and checks every padded pixel
// against a reference model of the border and RGB565 widening rules.
`default_nettype none
`timescale 1ns/100ps

`include "img_fetch_macros.svh"

module tb_img_fetch
    import img_mem_pkg::*;
    import img_pix_pkg::*;
();

    localparam int MEM_WORDS = 256;

    logic        s_clk;
    logic        s_rst;
    logic        awvalid;
    axil_addr_t  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    axil_addr_t  araddr;
    logic        rready;
    logic        pix_ready = 1'b1;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rd_req;
    mem_addr_t   rd_addr;
    burst_len_t  rd_len;
    logic        rd_valid;
    mem_word_t   rd_data;
    logic        rd_finish;
    logic        pix_valid;
    chan_t       pix_r;
    chan_t       pix_g;
    chan_t       pix_b;
    logic        pix_last;

    int          value_errors;
    int          other_errors;
    bit          timed_out;
    string       test_name;
    mem_addr_t   exp_base;
    int          exp_w;
    int          exp_h;
    int          chk_col;
    int          chk_row;
    int          last_count;
    bit          frame_active;
    bit          frame_end_seen;
    logic        bp_enable = 1'b0;
    integer      bp_seed = 29;
    logic        req_q = 1'b0;
    mem_addr_t   burst_addr_q[$];
    burst_len_t  burst_len_q[$];

    img_fetch_top i_dut (
        .s_clk (s_clk), .s_rst (s_rst),
        .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
        .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata),
        .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
        .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
        .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp),
        .o_rd_burst_req (rd_req), .o_rd_burst_addr (rd_addr),
        .o_rd_burst_len (rd_len), .i_rd_burst_valid (rd_valid),
        .i_rd_burst_data (rd_data), .i_rd_burst_finish (rd_finish),
        .o_pix_valid (pix_valid), .i_pix_ready (pix_ready),
        .o_pix_r (pix_r), .o_pix_g (pix_g), .o_pix_b (pix_b), .o_pix_last (pix_last)
    );

    tb_burst_mem #(.DEPTH(MEM_WORDS)) u_mem (
        .s_clk (s_clk), .i_req (rd_req), .i_addr (rd_addr), .i_len (rd_len),
        .o_valid (rd_valid), .o_data (rd_data), .o_finish (rd_finish)
    );

    initial begin
        s_clk = 1'b0;
        forever #5 s_clk = ~s_clk;
    end

    // expected padded pixel {r, g, b} at output position (col, row)
    function automatic logic [23:0] ref_pixel(input int col, input int row);
        int         p;
        mem_word_t  word;
        pix565_t    pix;
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        chan_t      r8;
        chan_t      g8;
        chan_t      b8;
        if (col == 0 || row == 0 || col == exp_w + 1 || row == exp_h + 1)
            return 24'd0;
        p = (row - 1) * exp_w + (col - 1);
        word = u_mem.mem[((exp_base >> 3) + p / 4) % MEM_WORDS];
        // first pixel of a word sits in the top halfword
        pix = word[63 - 16 * (p % 4) -: 16];
        r5 = pix[15:11];
        g6 = pix[10:5];
        b5 = pix[4:0];
        r8 = {r5, 3'b000} | chan_t'(r5 >> 2);
        g8 = {g6, 2'b00} | chan_t'(g6 >> 4);
        b8 = {b5, 3'b000} | chan_t'(b5 >> 2);
        return {r8, g8, b8};
    endfunction

    task automatic check_chan(input string what, input chan_t exp, input chan_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_last(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %b, actual %b", what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] exp,
                              input logic [1:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %b, actual %b", what, exp, act);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s in %s", what, test_name);
        other_errors++;
        timed_out = 1'b1;
    endtask

    task automatic axil_write(input axil_addr_t addr, input logic [31:0] data);
        int n;
        if (timed_out)
            return;
        @(posedge s_clk);
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        awaddr <= addr;
        wdata <= data;
        bready <= 1'b1;
        n = 0;
        @(posedge s_clk);
        while (!(awready && wready) && n < 20) begin
            @(posedge s_clk);
            n++;
        end
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (!(awready && wready)) begin
            report_timeout("AXI write address/data handshake");
            return;
        end
        n = 0;
        @(posedge s_clk);
        while (!bvalid && n < 20) begin
            @(posedge s_clk);
            n++;
        end
        bready <= 1'b0;
        if (bvalid)
            check_resp({test_name, " write response"}, 2'b00, bresp);
        else
            report_timeout("AXI write response");
    endtask

    task automatic axil_read(input axil_addr_t addr, output logic [31:0] data);
        int n;
        data = '0;
        if (timed_out)
            return;
        @(posedge s_clk);
        arvalid <= 1'b1;
        araddr <= addr;
        rready <= 1'b1;
        n = 0;
        @(posedge s_clk);
        while (!arready && n < 20) begin
            @(posedge s_clk);
            n++;
        end
        arvalid <= 1'b0;
        if (!arready) begin
            report_timeout("AXI read address handshake");
            return;
        end
        n = 0;
        @(posedge s_clk);
        while (!rvalid && n < 20) begin
            @(posedge s_clk);
            n++;
        end
        rready <= 1'b0;
        if (rvalid) begin
            data = rdata;
            check_resp({test_name, " read response"}, 2'b00, rresp);
        end else begin
            report_timeout("AXI read data");
        end
    endtask

    // set up, start and check one frame, including busy and done
    task automatic run_frame(input string name, input mem_addr_t base,
                             input int w, input int h);
        int          n;
        logic [31:0] status;
        test_name = name;
        axil_write(`IMG_REG_BASE, base);
        axil_write(`IMG_REG_WIDTH, w);
        axil_write(`IMG_REG_HEIGHT, h);
        exp_base = base;
        exp_w = w;
        exp_h = h;
        chk_col = 0;
        chk_row = 0;
        last_count = 0;
        frame_end_seen = 1'b0;
        frame_active = 1'b1;
        burst_addr_q.delete();
        burst_len_q.delete();
        axil_write(`IMG_REG_CTRL, 32'h1);
        axil_read(`IMG_REG_STATUS, status);
        check_reg({name, " status busy"}, 32'h1, status);
        n = 0;
        while (!frame_end_seen && !timed_out && n < 5000) begin
            @(posedge s_clk);
            n++;
        end
        if (!frame_end_seen && !timed_out)
            report_timeout("end of frame");
        axil_read(`IMG_REG_STATUS, status);
        check_reg({name, " status done"}, 32'h2, status);
        check_reg({name, " last count"}, 32'd1, last_count);
    endtask

    always @(posedge s_clk) begin
        if (bp_enable)
            pix_ready <= (({$random(bp_seed)} % 4) != 0);
        else
            pix_ready <= 1'b1;
    end

    // burst monitor at the memory port
    always @(posedge s_clk) begin
        if (rd_req && !req_q) begin
            burst_addr_q.push_back(rd_addr);
            burst_len_q.push_back(rd_len);
        end
        req_q <= rd_req;
    end

    always @(posedge s_clk) begin : check_output
        logic [23:0] exp_pix;
        logic        exp_last;
        string       where;
        if (!s_rst && pix_valid && pix_ready) begin
            if (!frame_active) begin
                $display("ERROR: pixel handed over outside a frame after %s", test_name);
                other_errors++;
            end else begin
                exp_pix = ref_pixel(chk_col, chk_row);
                exp_last = (chk_col == exp_w + 1) && (chk_row == exp_h + 1);
                where = $sformatf("%s (%0d,%0d)", test_name, chk_col, chk_row);
                check_chan({where, " red"}, exp_pix[23:16], pix_r);
                check_chan({where, " green"}, exp_pix[15:8], pix_g);
                check_chan({where, " blue"}, exp_pix[7:0], pix_b);
                check_last({where, " last"}, exp_last, pix_last);
                if (pix_last)
                    last_count++;
                if (exp_last) begin
                    frame_active = 1'b0;
                    frame_end_seen = 1'b1;
                end else if (chk_col == exp_w + 1) begin
                    chk_col = 0;
                    chk_row++;
                end else begin
                    chk_col++;
                end
            end
        end
    end

    initial begin : main_sequence
        logic [31:0] rd;
        s_rst = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        frame_active = 1'b0;
        frame_end_seen = 1'b0;
        last_count = 0;
        test_name = "reset";
        repeat (3) @(posedge s_clk);
        s_rst <= 1'b0;

        test_name = "regs";
        axil_read(`IMG_REG_STATUS, rd);
        check_reg("regs status after reset", 32'h0, rd);
        axil_write(`IMG_REG_BASE, 32'h1234_5678);
        axil_write(`IMG_REG_WIDTH, 32'h0000_0abc);
        axil_write(`IMG_REG_HEIGHT, 32'h0000_0456);
        axil_read(`IMG_REG_BASE, rd);
        check_reg("regs base", 32'h1234_5678, rd);
        axil_read(`IMG_REG_WIDTH, rd);
        check_reg("regs width", 32'h0000_0abc, rd);
        axil_read(`IMG_REG_HEIGHT, rd);
        check_reg("regs height", 32'h0000_0456, rd);
        axil_read(5'h14, rd);
        check_reg("regs unknown offset", 32'h0, rd);

        run_frame("frame 8x4", 32'h0000_0100, 8, 4);

        bp_enable <= 1'b1;
        run_frame("backpressure 16x6", 32'h0000_0200, 16, 6);
        bp_enable <= 1'b0;

        // 9 words: one full burst and a one-word tail
        run_frame("short burst 12x3", 32'h0000_03c0, 12, 3);
        check_reg("short burst count", 32'd2, burst_addr_q.size());
        if (burst_addr_q.size() >= 2) begin
            check_reg("short burst addr 0", 32'h0000_03c0, burst_addr_q[0]);
            check_reg("short burst len 0", 32'd8, burst_len_q[0]);
            check_reg("short burst addr 1", 32'h0000_0400, burst_addr_q[1]);
            check_reg("short burst len 1", 32'd1, burst_len_q[1]);
        end

        run_frame("restart 8x4", 32'h0000_0100, 8, 4);

        repeat (10) @(posedge s_clk);
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_burst_mem.sv */
// Behavioral burst-read memory for the image fetch testbench.
// Holds a random frame store and answers each request after 1 to 4 idle
// cycles with one word per cycle, pulsing finish with the last word.
`default_nettype none
`timescale 1ns/100ps

module tb_burst_mem
    import img_mem_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  wire        s_clk,
    input  wire        i_req,
    input  mem_addr_t  i_addr,
    input  burst_len_t i_len,
    output logic       o_valid,
    output mem_word_t  o_data,
    output logic       o_finish
);

    mem_word_t mem [DEPTH];
    integer    seed;

    initial begin
        seed = 29;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = {$random(seed), $random(seed)};
        o_valid = 1'b0;
        o_data = '0;
        o_finish = 1'b0;
    end

    always begin : serve_bursts
        int gap;
        int idx;
        int len_words;
        @(posedge s_clk);
        if (i_req) begin
            gap = 1 + ({$random(seed)} % 4);
            idx = int'(i_addr >> 3);
            len_words = int'(i_len);
            repeat (gap) @(posedge s_clk);
            for (int k = 0; k < len_words; k++) begin
                o_valid <= 1'b1;
                o_data <= mem[(idx + k) % DEPTH];
                o_finish <= (k == len_words - 1);
                @(posedge s_clk);
            end
            o_valid <= 1'b0;
            o_finish <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* img_fetch_top.sv */
// Image fetch subsystem: AXI4-Lite setup, burst reader with word FIFO,
// RGB565 unpack and zero-border padding toward the convolution layer.
`default_nettype none
`timescale 1ns/100ps

module img_fetch_top
    import img_mem_pkg::*;
    import img_pix_pkg::*;
(
    input  wire         s_clk,
    input  wire         s_rst,
    input  wire         i_awvalid,
    output logic        o_awready,
    input  axil_addr_t  i_awaddr,
    input  wire         i_wvalid,
    output logic        o_wready,
    input  wire [31:0]  i_wdata,
    output logic        o_bvalid,
    input  wire         i_bready,
    output logic [1:0]  o_bresp,
    input  wire         i_arvalid,
    output logic        o_arready,
    input  axil_addr_t  i_araddr,
    output logic        o_rvalid,
    input  wire         i_rready,
    output logic [31:0] o_rdata,
    output logic [1:0]  o_rresp,
    output logic        o_rd_burst_req,
    output mem_addr_t   o_rd_burst_addr,
    output burst_len_t  o_rd_burst_len,
    input  wire         i_rd_burst_valid,
    input  mem_word_t   i_rd_burst_data,
    input  wire         i_rd_burst_finish,
    output logic        o_pix_valid,
    input  wire         i_pix_ready,
    output chan_t       o_pix_r,
    output chan_t       o_pix_g,
    output chan_t       o_pix_b,
    output logic        o_pix_last
);

    logic      start;
    logic      frame_done;
    mem_addr_t base;
    img_dim_t  width;
    img_dim_t  height;
    logic      fifo_valid;
    logic      fifo_ready;
    pix565_t   fifo_pix;
    logic      unp_valid;
    logic      unp_ready;
    chan_t     unp_r;
    chan_t     unp_g;
    chan_t     unp_b;

    img_fetch_regs u_regs (
        .s_clk (s_clk), .s_rst (s_rst),
        .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awaddr (i_awaddr),
        .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata),
        .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bresp (o_bresp),
        .i_arvalid (i_arvalid), .o_arready (o_arready), .i_araddr (i_araddr),
        .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rdata (o_rdata),
        .o_rresp (o_rresp), .i_frame_done (frame_done),
        .o_start (start), .o_base (base), .o_width (width), .o_height (height)
    );

    img_burst_reader u_reader (
        .s_clk (s_clk), .s_rst (s_rst),
        .i_start (start), .i_base (base), .i_width (width), .i_height (height),
        .o_rd_burst_req (o_rd_burst_req), .o_rd_burst_addr (o_rd_burst_addr),
        .o_rd_burst_len (o_rd_burst_len), .i_rd_burst_valid (i_rd_burst_valid),
        .i_rd_burst_data (i_rd_burst_data), .i_rd_burst_finish (i_rd_burst_finish),
        .o_pix_valid (fifo_valid), .i_pix_ready (fifo_ready), .o_pix (fifo_pix)
    );

    img_pixel_unpack u_unpack (
        .s_clk (s_clk), .s_rst (s_rst),
        .i_valid (fifo_valid), .o_ready (fifo_ready), .i_pix (fifo_pix),
        .o_valid (unp_valid), .i_ready (unp_ready),
        .o_r (unp_r), .o_g (unp_g), .o_b (unp_b)
    );

    img_border_pad u_pad (
        .s_clk (s_clk), .s_rst (s_rst),
        .i_start (start), .i_width (width), .i_height (height),
        .i_valid (unp_valid), .o_ready (unp_ready),
        .i_r (unp_r), .i_g (unp_g), .i_b (unp_b),
        .o_valid (o_pix_valid), .i_ready (i_pix_ready),
        .o_r (o_pix_r), .o_g (o_pix_g), .o_b (o_pix_b),
        .o_last (o_pix_last), .o_frame_done (frame_done)
    );

endmodule

`default_nettype wire

/* img_border_pad.sv */
// Emits the frame with a one-pixel zero border in raster order.
// Border positions need no input; o_last marks the bottom-right corner.
`default_nettype none
`timescale 1ns/100ps

`include "img_fetch_macros.svh"

module img_border_pad
    import img_pix_pkg::*;
(
    input  wire      s_clk,
    input  wire      s_rst,
    input  wire      i_start,
    input  img_dim_t i_width,
    input  img_dim_t i_height,
    input  wire      i_valid,
    output logic     o_ready,
    input  chan_t    i_r,
    input  chan_t    i_g,
    input  chan_t    i_b,
    output logic     o_valid,
    input  wire      i_ready,
    output chan_t    o_r,
    output chan_t    o_g,
    output chan_t    o_b,
    output logic     o_last,
    output logic     o_frame_done
);

    pad_state_t               state;
    img_dim_t                 width;
    img_dim_t                 height;
    logic [`IMG_DIM_WIDTH:0]  col;
    logic [`IMG_DIM_WIDTH:0]  row;
    logic                     col_end;
    logic                     row_end;
    logic                     border;
    logic                     fire;

    assign col_end = (col == {1'b0, width} + 1'b1);
    assign row_end = (row == {1'b0, height} + 1'b1);
    assign border = (col == '0) || (row == '0) || col_end || row_end;

    assign o_valid = (state == PAD_RUN) && (border || i_valid);
    assign o_ready = (state == PAD_RUN) && !border && i_ready;
    assign o_r = border ? '0 : i_r;
    assign o_g = border ? '0 : i_g;
    assign o_b = border ? '0 : i_b;
    assign o_last = col_end && row_end;
    assign fire = o_valid && i_ready;
    assign o_frame_done = fire && o_last;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state <= PAD_IDLE;
            col <= '0;
            row <= '0;
            width <= '0;
            height <= '0;
        end else if (i_start) begin
            state <= PAD_RUN;
            col <= '0;
            row <= '0;
            width <= i_width;
            height <= i_height;
        end else if (fire) begin
            if (o_last) begin
                state <= PAD_DONE;
            end else if (col_end) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* img_pixel_unpack.sv */
// Register stage that widens RGB565 into three 8-bit channels.
// Top bits of each field are repeated into the low bits.
`default_nettype none
`timescale 1ns/100ps

module img_pixel_unpack
    import img_pix_pkg::*;
(
    input  wire     s_clk,
    input  wire     s_rst,
    input  wire     i_valid,
    output logic    o_ready,
    input  pix565_t i_pix,
    output logic    o_valid,
    input  wire     i_ready,
    output chan_t   o_r,
    output chan_t   o_g,
    output chan_t   o_b
);

    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            o_valid <= 1'b0;
        else if (o_ready)
            o_valid <= i_valid;
    end

    always_ff @(posedge s_clk) begin
        if (i_valid && o_ready) begin
            o_r <= {i_pix[15:11], i_pix[15:13]};
            o_g <= {i_pix[10:5], i_pix[10:9]};
            o_b <= {i_pix[4:0], i_pix[4:2]};
        end
    end

endmodule

`default_nettype wire

/* img_burst_reader.sv */
// Issues read bursts for one frame and fills the word FIFO.
// A burst is requested only when the FIFO has room for all of it.
// Halfwords are swapped so pixels come out of the FIFO in raster order.
`default_nettype none
`timescale 1ns/100ps

`include "img_fetch_macros.svh"

module img_burst_reader
    import img_mem_pkg::*;
    import img_pix_pkg::*;
(
    input  wire        s_clk,
    input  wire        s_rst,
    input  wire        i_start,
    input  mem_addr_t  i_base,
    input  img_dim_t   i_width,
    input  img_dim_t   i_height,
    output logic       o_rd_burst_req,
    output mem_addr_t  o_rd_burst_addr,
    output burst_len_t o_rd_burst_len,
    input  wire        i_rd_burst_valid,
    input  mem_word_t  i_rd_burst_data,
    input  wire        i_rd_burst_finish,
    output logic       o_pix_valid,
    input  wire        i_pix_ready,
    output pix565_t    o_pix
);

    localparam int FRAME_W = 2 * `IMG_DIM_WIDTH - 2;
    localparam int CNT_W = $clog2(`IMG_FIFO_WORDS) + 1;
    localparam int NPIX = `IMG_DATA_WIDTH / `IMG_PIX_WIDTH;

    logic [2*`IMG_DIM_WIDTH-1:0] frame_pixels;
    logic [FRAME_W-1:0]          words_left;
    logic [FRAME_W-1:0]          rem_src;
    logic [CNT_W-1:0]            in_flight;
    logic [CNT_W-1:0]            free_words;
    logic [CNT_W-1:0]            room;
    burst_len_t                  next_len;
    mem_addr_t                   next_addr;
    mem_word_t                   rev_word;
    logic                        issue;

    assign frame_pixels = i_width * i_height;
    // start reloads from the registers, otherwise continue the frame
    assign rem_src = i_start ? frame_pixels[2*`IMG_DIM_WIDTH-1:2] : words_left;
    assign room = i_start ? CNT_W'(`IMG_FIFO_WORDS) : free_words - in_flight;
    assign next_len = (rem_src > FRAME_W'(`IMG_BURST_LEN)) ?
                      burst_len_t'(`IMG_BURST_LEN) : rem_src[`IMG_LEN_WIDTH-1:0];
    assign next_addr = i_start ? i_base :
                       o_rd_burst_addr + (mem_addr_t'(o_rd_burst_len) << 3);
    assign issue = (i_start || !o_rd_burst_req) && (rem_src != '0)
                   && (room >= CNT_W'(next_len));

    always_comb begin
        for (int i = 0; i < NPIX; i++)
            rev_word[i*`IMG_PIX_WIDTH +: `IMG_PIX_WIDTH] =
                i_rd_burst_data[(NPIX-1-i)*`IMG_PIX_WIDTH +: `IMG_PIX_WIDTH];
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_rd_burst_req <= 1'b0;
            o_rd_burst_addr <= '0;
            o_rd_burst_len <= '0;
            words_left <= '0;
            in_flight <= '0;
        end else begin
            if (issue) begin
                o_rd_burst_req <= 1'b1;
                o_rd_burst_addr <= next_addr;
                o_rd_burst_len <= next_len;
                words_left <= rem_src - FRAME_W'(next_len);
            end else if (i_rd_burst_finish) begin
                o_rd_burst_req <= 1'b0;
            end

            // words requested but not yet written
            if (i_start)
                in_flight <= issue ? CNT_W'(next_len) : '0;
            else
                in_flight <= in_flight + (issue ? CNT_W'(next_len) : '0)
                             - CNT_W'(i_rd_burst_valid);
        end
    end

    img_word_fifo u_word_fifo (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_clear      (i_start),
        .i_wr_en      (i_rd_burst_valid),
        .i_wr_word    (rev_word),
        .o_free_words (free_words),
        .o_rd_valid   (o_pix_valid),
        .i_rd_ready   (i_pix_ready),
        .o_rd_pix     (o_pix)
    );

endmodule

`default_nettype wire

/* img_word_fifo.sv */
// Word FIFO with 64-bit writes and 16-bit pixel reads.
// Halfword 0 of each word is read first; the word is retired after the last.
`default_nettype none
`timescale 1ns/100ps

`include "img_fetch_macros.svh"

module img_word_fifo
    import img_mem_pkg::*;
    import img_pix_pkg::*;
(
    input  wire        s_clk,
    input  wire        s_rst,
    input  wire        i_clear,
    input  wire        i_wr_en,
    input  mem_word_t  i_wr_word,
    output logic [$clog2(`IMG_FIFO_WORDS):0] o_free_words,
    output logic       o_rd_valid,
    input  wire        i_rd_ready,
    output pix565_t    o_rd_pix
);

    localparam int PTR_W = $clog2(`IMG_FIFO_WORDS);
    localparam int NPIX = `IMG_DATA_WIDTH / `IMG_PIX_WIDTH;

    mem_word_t                   mem [`IMG_FIFO_WORDS];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic [$clog2(NPIX)-1:0]     sel;
    logic                        retire;

    assign o_rd_valid = (count != '0);
    assign o_rd_pix = mem[rd_ptr][sel*`IMG_PIX_WIDTH +: `IMG_PIX_WIDTH];
    assign retire = o_rd_valid && i_rd_ready && (sel == $clog2(NPIX)'(NPIX - 1));
    assign o_free_words = (PTR_W+1)'(`IMG_FIFO_WORDS) - count;

    always_ff @(posedge s_clk) begin
        if (i_wr_en)
            mem[wr_ptr] <= i_wr_word;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            sel <= '0;
        end else if (i_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            sel <= '0;
        end else begin
            if (i_wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (o_rd_valid && i_rd_ready)
                sel <= sel + 1'b1;
            if (retire)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(i_wr_en) - (PTR_W+1)'(retire);
        end
    end

endmodule

`default_nettype wire

/* img_fetch_regs.sv */
// AXI4-Lite slave holding the frame setup and the busy/done status.
// A write of 1 to CTRL bit 0 starts a frame; ignored while busy.
`default_nettype none
`timescale 1ns/100ps

`include "img_fetch_macros.svh"

module img_fetch_regs
    import img_mem_pkg::*;
    import img_pix_pkg::*;
(
    input  wire        s_clk,
    input  wire        s_rst,
    input  wire        i_awvalid,
    output logic       o_awready,
    input  axil_addr_t i_awaddr,
    input  wire        i_wvalid,
    output logic       o_wready,
    input  wire [31:0] i_wdata,
    output logic       o_bvalid,
    input  wire        i_bready,
    output logic [1:0] o_bresp,
    input  wire        i_arvalid,
    output logic       o_arready,
    input  axil_addr_t i_araddr,
    output logic       o_rvalid,
    input  wire        i_rready,
    output logic [31:0] o_rdata,
    output logic [1:0] o_rresp,
    input  wire        i_frame_done,
    output logic       o_start,
    output mem_addr_t  o_base,
    output img_dim_t   o_width,
    output img_dim_t   o_height
);

    logic wr_fire;
    logic rd_fire;
    logic busy;
    logic done;

    assign wr_fire = o_awready && i_awvalid && i_wvalid;
    assign rd_fire = o_arready && i_arvalid;
    // aw and w are taken together
    assign o_wready = o_awready;
    assign o_bresp = 2'b00;
    assign o_rresp = 2'b00;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_awready <= 1'b0;
            o_bvalid <= 1'b0;
            o_arready <= 1'b0;
            o_rvalid <= 1'b0;
            o_start <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            o_awready <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;
            if (wr_fire)
                o_bvalid <= 1'b1;
            else if (i_bready)
                o_bvalid <= 1'b0;

            o_arready <= i_arvalid && !o_arready && !o_rvalid;
            if (rd_fire)
                o_rvalid <= 1'b1;
            else if (i_rready)
                o_rvalid <= 1'b0;

            o_start <= wr_fire && (i_awaddr == `IMG_REG_CTRL) && i_wdata[0]
                       && !busy && !o_start;
            if (o_start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (i_frame_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (wr_fire) begin
            case (i_awaddr)
                `IMG_REG_BASE:   o_base <= i_wdata;
                `IMG_REG_WIDTH:  o_width <= i_wdata[`IMG_DIM_WIDTH-1:0];
                `IMG_REG_HEIGHT: o_height <= i_wdata[`IMG_DIM_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // read data is captured with the address
    always_ff @(posedge s_clk) begin
        if (rd_fire) begin
            case (i_araddr)
                `IMG_REG_STATUS: o_rdata <= {30'd0, done, busy};
                `IMG_REG_BASE:   o_rdata <= o_base;
                `IMG_REG_WIDTH:  o_rdata <= {20'd0, o_width};
                `IMG_REG_HEIGHT: o_rdata <= {20'd0, o_height};
                default:         o_rdata <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* img_pix_pkg.sv */
// Types for the pixel side: packed RGB565, widened channels,
// frame dimensions and the border padder state.
`default_nettype none

`include "img_fetch_macros.svh"

package img_pix_pkg;

    // red 15..11, green 10..5, blue 4..0
    typedef logic [`IMG_PIX_WIDTH-1:0]  pix565_t;
    typedef logic [`IMG_CHAN_WIDTH-1:0] chan_t;
    typedef logic [`IMG_DIM_WIDTH-1:0]  img_dim_t;

    typedef enum logic [1:0] {
        PAD_IDLE,
        PAD_RUN,
        PAD_DONE
    } pad_state_t;

endpackage

`default_nettype wire

/* img_mem_pkg.sv */
// Types for the memory side of the fetch path.
// Used by the register block, the burst reader and the word FIFO.
`default_nettype none

`include "img_fetch_macros.svh"

package img_mem_pkg;

    typedef logic [`IMG_ADDR_WIDTH-1:0]     mem_addr_t;
    typedef logic [`IMG_DATA_WIDTH-1:0]     mem_word_t;
    typedef logic [`IMG_LEN_WIDTH-1:0]      burst_len_t;
    // byte offset into the register map
    typedef logic [`IMG_REG_ADDR_WIDTH-1:0] axil_addr_t;

endpackage

`default_nettype wire

/* img_fetch_macros.svh */
// Shared constants for the image fetch subsystem.
// Include where widths, burst sizing or register offsets are needed.
`ifndef IMG_FETCH_MACROS_SVH
`define IMG_FETCH_MACROS_SVH

`define IMG_DATA_WIDTH      64
`define IMG_ADDR_WIDTH      32
`define IMG_BURST_LEN       8
`define IMG_LEN_WIDTH       8
`define IMG_FIFO_WORDS      32
`define IMG_DIM_WIDTH       12
`define IMG_PIX_WIDTH       16
`define IMG_CHAN_WIDTH      8
`define IMG_REG_ADDR_WIDTH  5

// AXI4-Lite register map
`define IMG_REG_CTRL        5'h00
`define IMG_REG_STATUS      5'h04
`define IMG_REG_BASE        5'h08
`define IMG_REG_WIDTH       5'h0C
`define IMG_REG_HEIGHT      5'h10

`endif
